//--- common/rank_sum_params.svh
//////////////////////////////////////////////////////////////////////
// widths, queue depths and lane count of the rank-sum unit
//////////////////////////////////////////////////////////////////////

`ifndef RANK_SUM_PARAMS_SVH
`define RANK_SUM_PARAMS_SVH

// lanes and the lane tag on reads
`define NUM_LANES          4
`define LANE_ID_W          2

// graph fields
`define VERTEX_ID_W        12
`define EDGE_IDX_W         16
`define DEGREE_W           8
`define RANK_W             16
`define SUM_W              24

// queue depths
`define VERTEX_FIFO_DEPTH  8
// neighbour queue depth is also the edge-read credit
`define LANE_PENDING_DEPTH 4

`endif

//--- common/rank_sum_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types for array kind, vertex job, read tag
// and the read response word
//////////////////////////////////////////////////////////////////////

`include "rank_sum_params.svh"

package rank_sum_pkg;

	// array addressed by a read
	typedef enum logic {
		EDGE_ARRAY = 1'b0,
		GRAPH_DATA = 1'b1
	} array_kind_t;

	// one vertex job, 36 bits
	typedef struct packed {
		logic [`VERTEX_ID_W-1:0] vertex_id;
		logic [`EDGE_IDX_W-1:0]  edge_start;
		logic [`DEGREE_W-1:0]    degree;
	} vertex_job_t;

	// echoed back by memory with every response
	typedef struct packed {
		array_kind_t           kind;
		logic [`LANE_ID_W-1:0] lane;
	} read_tag_t;

	// neighbour id sits in the low bits of an edge entry
	typedef struct packed {
		logic [`RANK_W-`VERTEX_ID_W-1:0] pad;
		logic [`VERTEX_ID_W-1:0]         neighbour;
	} edge_entry_t;

	// one response word, decoded by the tag kind
	typedef union packed {
		edge_entry_t        edge_entry;
		logic [`RANK_W-1:0] data_entry;
	} rsp_payload_u;

endpackage

//--- common/lane_if.sv
//////////////////////////////////////////////////////////////////////
// lane_read_if   read command and response path of one lane
// lane_result_if finished sum of one lane
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rank_sum_params.svh"

interface lane_read_if;

	// command side, held by the lane until granted
	logic                       cmd_valid;
	logic                       cmd_grant;
	rank_sum_pkg::array_kind_t  cmd_kind;
	logic [`EDGE_IDX_W-1:0]     cmd_addr;

	// response strobe from the router
	logic                       rsp_valid;
	rank_sum_pkg::array_kind_t  rsp_kind;
	rank_sum_pkg::rsp_payload_u rsp_payload;

	modport lane (
		output cmd_valid, cmd_kind, cmd_addr,
		input  cmd_grant, rsp_valid, rsp_kind, rsp_payload
	);

	modport drain (
		input  cmd_valid, cmd_kind, cmd_addr, rsp_valid, rsp_kind,
		output cmd_grant
	);

	modport router (
		output rsp_valid, rsp_kind, rsp_payload
	);

endinterface

interface lane_result_if;

	logic                    valid;
	logic                    grant;
	logic [`VERTEX_ID_W-1:0] vertex_id;
	logic [`SUM_W-1:0]       sum;

	modport lane (output valid, vertex_id, sum, input grant);
	modport drain (input valid, vertex_id, sum, output grant);

endinterface

//--- source/vertex_dispatch.sv
//////////////////////////////////////////////////////////////////////
// vertex job FIFO and hand-off of the head job to the
// lowest-numbered idle lane
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rank_sum_params.svh"

module vertex_dispatch (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      job_valid,
	input  logic [`VERTEX_ID_W-1:0]   job_vertex_id,
	input  logic [`EDGE_IDX_W-1:0]    job_edge_start,
	input  logic [`DEGREE_W-1:0]      job_degree,
	input  logic [`NUM_LANES-1:0]     lane_idle,
	output logic [`NUM_LANES-1:0]     lane_job_valid,
	output rank_sum_pkg::vertex_job_t lane_job,
	output logic                      vertex_job_request
);

	localparam int PTR_W = $clog2(`VERTEX_FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	rank_sum_pkg::vertex_job_t job_mem [`VERTEX_FIFO_DEPTH];
	logic [PTR_W-1:0]          wr_ptr;
	logic [PTR_W-1:0]          rd_ptr;
	logic [CNT_W-1:0]          count;
	logic                      empty;
	logic                      pop;

	assign empty              = (count == '0);
	assign pop                = !empty && (|lane_idle);
	assign lane_job           = job_mem[rd_ptr];
	assign vertex_job_request = empty;

	// isolate the lowest set idle bit
	assign lane_job_valid = empty ? '0 : (lane_idle & (~lane_idle + 1'b1));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (job_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(job_valid) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clock) begin
		if (job_valid) begin
			job_mem[wr_ptr] <= {job_vertex_id, job_edge_start, job_degree};
		end
	end

	// the job source must respect the queue depth
	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		job_valid |-> (count < `VERTEX_FIFO_DEPTH));

endmodule

//--- source/response_router.sv
//////////////////////////////////////////////////////////////////////
// registered decode of the response tag onto one lane strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rank_sum_params.svh"

module response_router (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      rsp_valid,
	input  rank_sum_pkg::array_kind_t rsp_kind,
	input  logic [`LANE_ID_W-1:0]     rsp_lane,
	input  logic [`RANK_W-1:0]        rsp_payload,
	lane_read_if.router               rd [`NUM_LANES]
);

	logic                       valid_q;
	rank_sum_pkg::read_tag_t    tag_q;
	rank_sum_pkg::rsp_payload_u payload_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= rsp_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (rsp_valid) begin
			tag_q.kind <= rsp_kind;
			tag_q.lane <= rsp_lane;
			payload_q  <= rsp_payload;
		end
	end

	// only the tagged lane sees the strobe
	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_steer
		localparam logic [`LANE_ID_W-1:0] LANE = i;
		assign rd[i].rsp_valid   = valid_q && (tag_q.lane == LANE);
		assign rd[i].rsp_kind    = tag_q.kind;
		assign rd[i].rsp_payload = payload_q;
	end

	// tag of a response is fully driven
	a_tag_known: assert property (@(posedge clock) disable iff (!rstn)
		rsp_valid |-> !$isunknown({rsp_kind, rsp_lane}));

endmodule

//--- source/lane_drain.sv
//////////////////////////////////////////////////////////////////////
// round-robin drain of lane read commands and lane results
// onto the registered top-level ports, plus vertex and edge counters
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rank_sum_params.svh"

module lane_drain (
	input  logic                      clock,
	input  logic                      rstn,
	lane_read_if.drain                rd  [`NUM_LANES],
	lane_result_if.drain              res [`NUM_LANES],
	output logic                      cmd_valid,
	output rank_sum_pkg::array_kind_t cmd_kind,
	output logic [`LANE_ID_W-1:0]     cmd_lane,
	output logic [`EDGE_IDX_W-1:0]    cmd_addr,
	output logic                      result_valid,
	output logic [`VERTEX_ID_W-1:0]   result_vertex_id,
	output logic [`SUM_W-1:0]         result_sum,
	output logic [`VERTEX_ID_W-1:0]   vertex_count,
	output logic [`EDGE_IDX_W-1:0]    edge_count
);

	logic [`NUM_LANES-1:0]     cmd_held;
	logic [`NUM_LANES-1:0]     cmd_req;
	logic [`NUM_LANES-1:0]     cmd_win;
	logic [`NUM_LANES-1:0]     cmd_gnt_q;
	logic [`LANE_ID_W-1:0]     cmd_idx;
	logic [`LANE_ID_W-1:0]     cmd_last;
	rank_sum_pkg::array_kind_t cmd_kind_a [`NUM_LANES];
	logic [`EDGE_IDX_W-1:0]    cmd_addr_a [`NUM_LANES];

	logic [`NUM_LANES-1:0]     res_held;
	logic [`NUM_LANES-1:0]     res_req;
	logic [`NUM_LANES-1:0]     res_win;
	logic [`NUM_LANES-1:0]     res_gnt_q;
	logic [`LANE_ID_W-1:0]     res_idx;
	logic [`LANE_ID_W-1:0]     res_last;
	logic [`VERTEX_ID_W-1:0]   res_vid_a  [`NUM_LANES];
	logic [`SUM_W-1:0]         res_sum_a  [`NUM_LANES];

	logic [`NUM_LANES-1:0]     data_rsp;

	// first requester after the last winner
	function automatic logic [`NUM_LANES-1:0] rr_pick(
		input logic [`NUM_LANES-1:0] req,
		input logic [`LANE_ID_W-1:0] last
	);
		logic [`NUM_LANES-1:0] gnt;
		logic [`LANE_ID_W-1:0] idx;
		gnt = '0;
		// walk from farthest to nearest, nearest overwrites
		for (int k = `NUM_LANES; k >= 1; k--) begin
			idx = last + k[`LANE_ID_W-1:0];
			if (req[idx]) begin
				gnt      = '0;
				gnt[idx] = 1'b1;
			end
		end
		return gnt;
	endfunction

	function automatic logic [`LANE_ID_W-1:0] to_index(input logic [`NUM_LANES-1:0] onehot);
		logic [`LANE_ID_W-1:0] idx;
		idx = '0;
		for (int k = 0; k < `NUM_LANES; k++) begin
			if (onehot[k]) begin
				idx = k[`LANE_ID_W-1:0];
			end
		end
		return idx;
	endfunction

	// a lane already granted this cycle does not bid again
	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		assign cmd_held[i]     = rd[i].cmd_valid;
		assign cmd_req[i]      = cmd_held[i] && !cmd_gnt_q[i];
		assign cmd_kind_a[i]   = rd[i].cmd_kind;
		assign cmd_addr_a[i]   = rd[i].cmd_addr;
		assign rd[i].cmd_grant = cmd_gnt_q[i];
		assign data_rsp[i]     = rd[i].rsp_valid && (rd[i].rsp_kind == rank_sum_pkg::GRAPH_DATA);
		assign res_held[i]     = res[i].valid;
		assign res_req[i]      = res_held[i] && !res_gnt_q[i];
		assign res_vid_a[i]    = res[i].vertex_id;
		assign res_sum_a[i]    = res[i].sum;
		assign res[i].grant    = res_gnt_q[i];
	end

	assign cmd_win = rr_pick(cmd_req, cmd_last);
	assign res_win = rr_pick(res_req, res_last);
	assign cmd_idx = to_index(cmd_win);
	assign res_idx = to_index(res_win);

	//////////////////////////////////////////////////////////////////////
	// grants, strobes and counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_gnt_q    <= '0;
			cmd_last     <= '0;
			cmd_valid    <= 1'b0;
			res_gnt_q    <= '0;
			res_last     <= '0;
			result_valid <= 1'b0;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			cmd_gnt_q    <= cmd_win;
			cmd_valid    <= |cmd_win;
			res_gnt_q    <= res_win;
			result_valid <= |res_win;
			if (|cmd_win) begin
				cmd_last <= cmd_idx;
			end
			if (|res_win) begin
				res_last     <= res_idx;
				vertex_count <= vertex_count + 1'b1;
			end
			if (|data_rsp) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

	// winner payloads
	always_ff @(posedge clock) begin
		if (|cmd_win) begin
			cmd_kind <= cmd_kind_a[cmd_idx];
			cmd_lane <= cmd_idx;
			cmd_addr <= cmd_addr_a[cmd_idx];
		end
		if (|res_win) begin
			result_vertex_id <= res_vid_a[res_idx];
			result_sum       <= res_sum_a[res_idx];
		end
	end

	// granted lane still holds its request
	a_one_grant: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cmd_gnt_q) && $onehot0(res_gnt_q)
		&& ((cmd_gnt_q & ~cmd_held) == '0) && ((res_gnt_q & ~res_held) == '0));

endmodule

//--- lane/rank_lane.sv
//////////////////////////////////////////////////////////////////////
// one rank-sum lane
// edge walk, neighbour FIFO, graph-data reads and summing
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rank_sum_params.svh"

module rank_lane (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      job_valid,
	input  rank_sum_pkg::vertex_job_t job,
	output logic                      idle,
	lane_read_if.lane                 rd,
	lane_result_if.lane               res
);

	localparam int PTR_W = $clog2(`LANE_PENDING_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	logic                      busy;
	logic [`VERTEX_ID_W-1:0]   vertex_id_q;
	logic [`DEGREE_W-1:0]      degree_q;
	logic [`EDGE_IDX_W-1:0]    edge_idx;
	logic [`DEGREE_W-1:0]      edge_cnt;
	logic [`DEGREE_W-1:0]      data_cnt;
	logic [CNT_W-1:0]          credit_used;
	logic [`SUM_W-1:0]         sum_q;
	logic                      res_valid_q;

	// neighbour ids waiting for their data read
	logic [`VERTEX_ID_W-1:0]   nbr_mem [`LANE_PENDING_DEPTH];
	logic [PTR_W-1:0]          nbr_wr_ptr;
	logic [PTR_W-1:0]          nbr_rd_ptr;
	logic [CNT_W-1:0]          nbr_count;

	logic                      cmd_valid_q;
	rank_sum_pkg::array_kind_t cmd_kind_q;
	logic [`EDGE_IDX_W-1:0]    cmd_addr_q;
	logic                      cmd_free;
	logic                      load_data;
	logic                      load_edge;
	logic                      nbr_push;
	logic                      data_rsp;

	assign idle          = !busy;
	assign rd.cmd_valid  = cmd_valid_q;
	assign rd.cmd_kind   = cmd_kind_q;
	assign rd.cmd_addr   = cmd_addr_q;
	assign res.valid     = res_valid_q;
	assign res.vertex_id = vertex_id_q;
	assign res.sum       = sum_q;

	assign nbr_push = rd.rsp_valid && (rd.rsp_kind == rank_sum_pkg::EDGE_ARRAY);
	assign data_rsp = rd.rsp_valid && (rd.rsp_kind == rank_sum_pkg::GRAPH_DATA);

	// next command loads when the slot is empty or just granted
	assign cmd_free  = !cmd_valid_q || rd.cmd_grant;
	assign load_data = busy && cmd_free && (nbr_count != '0);
	assign load_edge = busy && cmd_free && !load_data && (edge_cnt != degree_q)
		&& (credit_used < `LANE_PENDING_DEPTH);

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy        <= 1'b0;
			res_valid_q <= 1'b0;
			cmd_valid_q <= 1'b0;
			edge_cnt    <= '0;
			data_cnt    <= '0;
			credit_used <= '0;
			nbr_wr_ptr  <= '0;
			nbr_rd_ptr  <= '0;
			nbr_count   <= '0;
		end else if (job_valid) begin
			busy        <= 1'b1;
			// degree 0 finishes at once
			res_valid_q <= (job.degree == '0);
			edge_cnt    <= '0;
			data_cnt    <= '0;
			credit_used <= '0;
		end else begin
			if (res.grant) begin
				busy        <= 1'b0;
				res_valid_q <= 1'b0;
			end
			if (data_rsp) begin
				data_cnt <= data_cnt + 1'b1;
				if (data_cnt + 1'b1 == degree_q) begin
					res_valid_q <= 1'b1;
				end
			end
			if (load_data || load_edge) begin
				cmd_valid_q <= 1'b1;
			end else if (rd.cmd_grant) begin
				cmd_valid_q <= 1'b0;
			end
			if (load_edge) begin
				edge_cnt <= edge_cnt + 1'b1;
			end
			// credit returns when the neighbour leaves the FIFO
			credit_used <= credit_used + CNT_W'(load_edge) - CNT_W'(load_data);
			if (nbr_push) begin
				nbr_wr_ptr <= nbr_wr_ptr + 1'b1;
			end
			if (load_data) begin
				nbr_rd_ptr <= nbr_rd_ptr + 1'b1;
			end
			nbr_count <= nbr_count + CNT_W'(nbr_push) - CNT_W'(load_data);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (job_valid) begin
			vertex_id_q <= job.vertex_id;
			degree_q    <= job.degree;
			edge_idx    <= job.edge_start;
			sum_q       <= '0;
		end else begin
			if (data_rsp) begin
				// wraps modulo 2**SUM_W
				sum_q <= sum_q + {{(`SUM_W-`RANK_W){1'b0}}, rd.rsp_payload.data_entry};
			end
			if (load_edge) begin
				edge_idx <= edge_idx + 1'b1;
			end
		end
		if (nbr_push) begin
			nbr_mem[nbr_wr_ptr] <= rd.rsp_payload.edge_entry.neighbour;
		end
		if (load_data) begin
			cmd_kind_q <= rank_sum_pkg::GRAPH_DATA;
			cmd_addr_q <= {{(`EDGE_IDX_W-`VERTEX_ID_W){1'b0}}, nbr_mem[nbr_rd_ptr]};
		end else if (load_edge) begin
			cmd_kind_q <= rank_sum_pkg::EDGE_ARRAY;
			cmd_addr_q <= edge_idx;
		end
	end

	// memory only answers reads this lane issued for its job
	a_rsp_when_busy: assert property (@(posedge clock) disable iff (!rstn)
		rd.rsp_valid |-> busy);

endmodule

//--- source/rank_sum_cu.sv
//////////////////////////////////////////////////////////////////////
// rank-sum compute unit top level
// job dispatch, response router, drain arbiters and the lane array
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rank_sum_params.svh"

module rank_sum_cu (
	input  logic                      clock,
	input  logic                      rstn,
	// vertex jobs
	input  logic                      job_valid,
	input  logic [`VERTEX_ID_W-1:0]   job_vertex_id,
	input  logic [`EDGE_IDX_W-1:0]    job_edge_start,
	input  logic [`DEGREE_W-1:0]      job_degree,
	output logic                      vertex_job_request,
	// memory read responses
	input  logic                      rsp_valid,
	input  rank_sum_pkg::array_kind_t rsp_kind,
	input  logic [`LANE_ID_W-1:0]     rsp_lane,
	input  logic [`RANK_W-1:0]        rsp_payload,
	// memory read commands
	output logic                      cmd_valid,
	output rank_sum_pkg::array_kind_t cmd_kind,
	output logic [`LANE_ID_W-1:0]     cmd_lane,
	output logic [`EDGE_IDX_W-1:0]    cmd_addr,
	// results and counters
	output logic                      result_valid,
	output logic [`VERTEX_ID_W-1:0]   result_vertex_id,
	output logic [`SUM_W-1:0]         result_sum,
	output logic [`VERTEX_ID_W-1:0]   vertex_count,
	output logic [`EDGE_IDX_W-1:0]    edge_count
);

	logic [`NUM_LANES-1:0]     lane_idle;
	logic [`NUM_LANES-1:0]     lane_job_valid;
	rank_sum_pkg::vertex_job_t lane_job;

	lane_read_if   rd_if  [`NUM_LANES] ();
	lane_result_if res_if [`NUM_LANES] ();

	vertex_dispatch u_dispatch (
		.clock             (clock),
		.rstn              (rstn),
		.job_valid         (job_valid),
		.job_vertex_id     (job_vertex_id),
		.job_edge_start    (job_edge_start),
		.job_degree        (job_degree),
		.lane_idle         (lane_idle),
		.lane_job_valid    (lane_job_valid),
		.lane_job          (lane_job),
		.vertex_job_request(vertex_job_request)
	);

	response_router u_router (
		.clock      (clock),
		.rstn       (rstn),
		.rsp_valid  (rsp_valid),
		.rsp_kind   (rsp_kind),
		.rsp_lane   (rsp_lane),
		.rsp_payload(rsp_payload),
		.rd         (rd_if)
	);

	lane_drain u_drain (
		.clock           (clock),
		.rstn            (rstn),
		.rd              (rd_if),
		.res             (res_if),
		.cmd_valid       (cmd_valid),
		.cmd_kind        (cmd_kind),
		.cmd_lane        (cmd_lane),
		.cmd_addr        (cmd_addr),
		.result_valid    (result_valid),
		.result_vertex_id(result_vertex_id),
		.result_sum      (result_sum),
		.vertex_count    (vertex_count),
		.edge_count      (edge_count)
	);

	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		rank_lane u_lane (
			.clock    (clock),
			.rstn     (rstn),
			.job_valid(lane_job_valid[i]),
			.job      (lane_job),
			.idle     (lane_idle[i]),
			.rd       (rd_if[i]),
			.res      (res_if[i])
		);
	end

endmodule

//--- testbench/graph_contents.svh
//////////////////////////////////////////////////////////////////////
// graph contents seen by the testbench
// edge entry per edge index and rank value per vertex
//////////////////////////////////////////////////////////////////////

// neighbour id stored at an edge index
function automatic logic [`VERTEX_ID_W-1:0] edge_entry_of(input logic [`EDGE_IDX_W-1:0] idx);
	return `VERTEX_ID_W'((int'(idx) * 7 + 3) % 4096);
endfunction

// rank value stored for a vertex
function automatic logic [`RANK_W-1:0] rank_of(input logic [`VERTEX_ID_W-1:0] v);
	return `RANK_W'((int'(v) * 13 + 5) % 65536);
endfunction

//--- testbench/tb_graph_memory.sv
//////////////////////////////////////////////////////////////////////
// graph memory model, one response per read command
// after a random latency, out of order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rank_sum_params.svh"

module tb_graph_memory (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      cmd_valid,
	input  rank_sum_pkg::array_kind_t cmd_kind,
	input  logic [`LANE_ID_W-1:0]     cmd_lane,
	input  logic [`EDGE_IDX_W-1:0]    cmd_addr,
	output logic                      rsp_valid,
	output rank_sum_pkg::array_kind_t rsp_kind,
	output logic [`LANE_ID_W-1:0]     rsp_lane,
	output logic [`RANK_W-1:0]        rsp_payload
);

	`include "graph_contents.svh"

	// reads waiting for their response
	rank_sum_pkg::array_kind_t kind_q [$];
	logic [`LANE_ID_W-1:0]     lane_q [$];
	logic [`EDGE_IDX_W-1:0]    addr_q [$];
	int                        due_q  [$];

	initial begin
		int cycle;
		int sel;
		cycle       = 0;
		rsp_valid   = 1'b0;
		rsp_kind    = rank_sum_pkg::EDGE_ARRAY;
		rsp_lane    = '0;
		rsp_payload = '0;
		forever begin
			// commands are stable at the falling edge
			@(negedge clock);
			cycle++;
			if (rstn && cmd_valid) begin
				kind_q.push_back(cmd_kind);
				lane_q.push_back(cmd_lane);
				addr_q.push_back(cmd_addr);
				due_q.push_back(cycle + int'($urandom_range(12, 1)) - 1);
			end
			@(posedge clock);
			#1;
			rsp_valid = 1'b0;
			// first read that is due, so later reads can overtake
			sel = -1;
			for (int k = 0; k < due_q.size(); k++) begin
				if (sel < 0 && due_q[k] <= cycle) begin
					sel = k;
				end
			end
			if (sel >= 0) begin
				rsp_valid = 1'b1;
				rsp_kind  = kind_q[sel];
				rsp_lane  = lane_q[sel];
				if (kind_q[sel] == rank_sum_pkg::EDGE_ARRAY) begin
					rsp_payload = `RANK_W'(edge_entry_of(addr_q[sel]));
				end else begin
					rsp_payload = rank_of(addr_q[sel][`VERTEX_ID_W-1:0]);
				end
				kind_q.delete(sel);
				lane_q.delete(sel);
				addr_q.delete(sel);
				due_q.delete(sel);
			end
		end
	end

endmodule

//--- testbench/tb_rank_sum_cu.sv
//////////////////////////////////////////////////////////////////////
// testbench for the rank-sum unit
// clock, reset, job stimulus, reference sums, scoreboard and checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rank_sum_params.svh"

module tb_rank_sum_cu;

	localparam int WAIT_LIMIT = 20000;

	logic                      clock = 1'b0;
	logic                      rstn;
	logic                      job_valid;
	logic [`VERTEX_ID_W-1:0]   job_vertex_id;
	logic [`EDGE_IDX_W-1:0]    job_edge_start;
	logic [`DEGREE_W-1:0]      job_degree;
	logic                      vertex_job_request;
	logic                      rsp_valid;
	rank_sum_pkg::array_kind_t rsp_kind;
	logic [`LANE_ID_W-1:0]     rsp_lane;
	logic [`RANK_W-1:0]        rsp_payload;
	logic                      cmd_valid;
	rank_sum_pkg::array_kind_t cmd_kind;
	logic [`LANE_ID_W-1:0]     cmd_lane;
	logic [`EDGE_IDX_W-1:0]    cmd_addr;
	logic                      result_valid;
	logic [`VERTEX_ID_W-1:0]   result_vertex_id;
	logic [`SUM_W-1:0]         result_sum;
	logic [`VERTEX_ID_W-1:0]   vertex_count;
	logic [`EDGE_IDX_W-1:0]    edge_count;

	// scoreboard keyed by vertex id
	logic [`SUM_W-1:0] exp_sum     [1 << `VERTEX_ID_W];
	logic              exp_pending [1 << `VERTEX_ID_W];
	int                results_seen = 0;
	int                edge_cmds = 0;
	int                data_cmds = 0;
	int                total_degree = 0;

	`include "graph_contents.svh"

	rank_sum_cu dut0 (.*);

	tb_graph_memory memory0 (.*);

	always #4 clock = ~clock;

	// reference sum over the edge list, wraps modulo 2**SUM_W
	function automatic logic [`SUM_W-1:0] expected_sum(
		input logic [`EDGE_IDX_W-1:0] start,
		input logic [`DEGREE_W-1:0]   degree
	);
		logic [`SUM_W-1:0]      acc;
		logic [`EDGE_IDX_W-1:0] idx;
		acc = '0;
		for (int k = 0; k < int'(degree); k++) begin
			idx = start + `EDGE_IDX_W'(k);
			acc = acc + `SUM_W'(rank_of(edge_entry_of(idx)));
		end
		return acc;
	endfunction

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("timeout while waiting for %s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic send_job(
		input logic [`VERTEX_ID_W-1:0] vid,
		input logic [`EDGE_IDX_W-1:0]  start,
		input logic [`DEGREE_W-1:0]    degree
	);
		@(posedge clock);
		#1;
		exp_sum[vid]     = expected_sum(start, degree);
		exp_pending[vid] = 1'b1;
		total_degree     = total_degree + int'(degree);
		job_valid        = 1'b1;
		job_vertex_id    = vid;
		job_edge_start   = start;
		job_degree       = degree;
	endtask

	task automatic stop_jobs();
		@(posedge clock);
		#1;
		job_valid = 1'b0;
	endtask

	task automatic wait_results(input int count, input string what);
		int cycles;
		cycles = 0;
		while (results_seen < count) begin
			@(negedge clock);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run(what);
			end
		end
	endtask

	task automatic wait_job_request();
		int cycles;
		cycles = 0;
		while (!vertex_job_request) begin
			@(negedge clock);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run("vertex_job_request to return to 1");
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare and command count
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (rstn && result_valid) begin
			check_value("pending flag of result vertex", 32'(exp_pending[result_vertex_id]), 1);
			check_value("result_sum", 32'(result_sum), 32'(exp_sum[result_vertex_id]));
			exp_pending[result_vertex_id] = 1'b0;
			results_seen++;
		end
		if (rstn && cmd_valid) begin
			if (cmd_kind == rank_sum_pkg::EDGE_ARRAY) begin
				edge_cmds++;
			end else begin
				data_cmds++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(58));
		foreach (exp_pending[v]) begin
			exp_pending[v] = 1'b0;
		end
		rstn           = 1'b0;
		job_valid      = 1'b0;
		job_vertex_id  = '0;
		job_edge_start = '0;
		job_degree     = '0;
		repeat (8) @(posedge clock);
		#1;
		rstn = 1'b1;
		@(negedge clock);
		#1;

		// state right after reset
		check_value("cmd_valid after reset", 32'(cmd_valid), 0);
		check_value("result_valid after reset", 32'(result_valid), 0);
		check_value("vertex_count after reset", 32'(vertex_count), 0);
		check_value("edge_count after reset", 32'(edge_count), 0);
		check_value("vertex_job_request after reset", 32'(vertex_job_request), 1);

		// one job of degree 5
		send_job(12'd10, 16'd100, 8'd5);
		stop_jobs();
		wait_results(1, "the result of the degree 5 job");
		check_value("edge reads of degree 5 job", 32'(edge_cmds), 5);
		check_value("data reads of degree 5 job", 32'(data_cmds), 5);
		check_value("vertex_count after one job", 32'(vertex_count), 1);

		// degree 0, no reads at all
		edge_cmds = 0;
		data_cmds = 0;
		send_job(12'd20, 16'd300, 8'd0);
		stop_jobs();
		wait_results(2, "the result of the degree 0 job");
		check_value("edge reads of degree 0 job", 32'(edge_cmds), 0);
		check_value("data reads of degree 0 job", 32'(data_cmds), 0);
		check_value("vertex_count after degree 0 job", 32'(vertex_count), 2);

		// eight jobs back to back, more than the lanes hold
		for (int j = 0; j < 8; j++) begin
			send_job(12'(100 + j), 16'($urandom_range(4000, 0)), 8'($urandom_range(20, 1)));
		end
		stop_jobs();
		check_value("vertex_job_request with jobs queued", 32'(vertex_job_request), 0);
		wait_job_request();
		check_value("results still open when queue drains", 32'(results_seen < 10), 1);
		wait_results(10, "the results of the eight random jobs");
		check_value("vertex_count after random jobs", 32'(vertex_count), 10);
		check_value("edge_count after random jobs", 32'(edge_count), total_degree);

		// longest job the degree field allows
		send_job(12'd300, 16'd585, 8'd255);
		stop_jobs();
		wait_results(11, "the result of the degree 255 job");
		check_value("vertex_count at the end", 32'(vertex_count), 11);
		check_value("edge_count at the end", 32'(edge_count), total_degree);

		$display("Test OK");
		$finish;
	end

endmodule

//--- rank_sum_cu.f
+incdir+common
+incdir+testbench
common/rank_sum_pkg.sv
common/lane_if.sv
source/vertex_dispatch.sv
source/response_router.sv
source/lane_drain.sv
lane/rank_lane.sv
source/rank_sum_cu.sv
testbench/tb_graph_memory.sv
testbench/tb_rank_sum_cu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_rank_sum_cu
RTL_TOP    := rank_sum_cu
FILELIST   := rank_sum_cu.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
